//--- flist.f
+incdir+verif
hw/merge_pkg.sv
hw/cas_column.sv
hw/bitonic_merge_net.sv
hw/block_fifo.sv
hw/credit_sender.sv
hw/merge_unit_top.sv
verif/tb_merge_unit.sv

//--- run_sim.sh
#!/bin/sh
# Builds the merge unit testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_merge_unit -f flist.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/Vtb_merge_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "tests failed" "$LOG"; then
   echo "Simulation reported failures, see $LOG"
   exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- verif/tb_vectors.svh
// Directed table for the merge unit testbench.
// Each row holds list A, list B and the expected ascending merge.

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

   localparam int NUM_VEC = 6;

   // Rows are interleaved, A below B, B below A, duplicates, all equal and extreme keys.
   localparam key_t VEC_A [NUM_VEC][DEF_BLK_N] = '{
      '{1, 3, 5, 7, 9, 11, 13, 15},
      '{1, 2, 3, 4, 5, 6, 7, 8},
      '{60, 61, 62, 63, 64, 65, 66, 67},
      '{2, 2, 4, 4, 6, 8, 8, 9},
      '{7, 7, 7, 7, 7, 7, 7, 7},
      '{0, 0, 1, 5, 9, 100, 200, 32'hFFFFFFFF}
   };

   localparam key_t VEC_B [NUM_VEC][DEF_BLK_N] = '{
      '{2, 4, 6, 8, 10, 12, 14, 16},
      '{20, 21, 22, 23, 24, 25, 26, 27},
      '{30, 31, 32, 33, 34, 35, 36, 37},
      '{2, 3, 4, 6, 6, 8, 9, 9},
      '{7, 7, 7, 7, 7, 7, 7, 7},
      '{0, 3, 5, 50, 300, 1000, 32'hFFFFFFFE, 32'hFFFFFFFF}
   };

   localparam key_t VEC_EXP [NUM_VEC][2*DEF_BLK_N] = '{
      '{1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15, 16},
      '{1, 2, 3, 4, 5, 6, 7, 8, 20, 21, 22, 23, 24, 25, 26, 27},
      '{30, 31, 32, 33, 34, 35, 36, 37, 60, 61, 62, 63, 64, 65, 66, 67},
      '{2, 2, 2, 3, 4, 4, 4, 6, 6, 6, 8, 8, 8, 9, 9, 9},
      '{7, 7, 7, 7, 7, 7, 7, 7, 7, 7, 7, 7, 7, 7, 7, 7},
      '{0, 0, 0, 1, 3, 5, 5, 9, 50, 100, 200, 300, 1000,
        32'hFFFFFFFE, 32'hFFFFFFFF, 32'hFFFFFFFF}
   };

`endif

//--- verif/tb_merge_unit.sv
// Testbench for the streaming merge unit.
// Producer and consumer credit models, directed table, back-pressure and random phases.

`timescale 1ns/1ps
`default_nettype none

module tb_merge_unit
   import merge_pkg::*;
();

   localparam int NK       = 2 * DEF_BLK_N;
   localparam int TIMEOUT  = 300;  // Cycles allowed for any single wait.
   localparam int N_RANDOM = 40;

   `include "tb_vectors.svh"

   typedef key_t [DEF_BLK_N-1:0] list_t;
   typedef key_t [NK-1:0]        block_t;

   logic   i_clk;
   logic   i_arst_n;
   logic   i_in_valid;
   list_t  i_in_list_a;
   list_t  i_in_list_b;
   tag_t   i_in_tag;
   logic   i_out_credit = 1'b0;
   logic   o_in_credit;
   logic   o_out_valid;
   block_t o_out_keys;
   tag_t   o_out_tag;

   block_t exp_keys [256];  // Expected merge of block n, whose tag is n.
   int errors   = 0;
   int spent    = 0;        // Input credits used, one per block sent.
   int returned = 0;
   int consumed = 0;
   int given    = 0;        // Credits handed back to the DUT.
   int policy   = 0;        // 0 returns credits at once, 1 holds them, 2 returns at random.
   int seed     = 59;
   bit give_ok  = 1'b0;

   merge_unit_top merge_unit_top_inst (.*);

   always #10 i_clk = ~i_clk;

   task automatic check_keys(input string name, input block_t exp, input block_t act);
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_tag(input string name, input tag_t exp, input tag_t act);
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      end
   endtask

   function automatic int producer_credits();
      return DEF_FIFO_DEPTH - spent + returned;
   endfunction

   function automatic block_t merge_expected(input list_t a, input list_t b);
      key_t   q [$];
      block_t res;
      for (int k = 0; k < DEF_BLK_N; k++) begin
         q.push_back(a[k]);
         q.push_back(b[k]);
      end
      q.sort();
      foreach (q[k]) res[k] = q[k];
      return res;
   endfunction

   function automatic list_t random_list();
      key_t  q [$];
      list_t res;
      for (int k = 0; k < DEF_BLK_N; k++) begin
         q.push_back(key_t'($random(seed)));
      end
      q.sort();
      foreach (q[k]) res[k] = q[k];
      return res;
   endfunction

   task automatic send_block(input list_t a, input list_t b, input block_t exp);
      int t = 0;
      while (producer_credits() == 0 && t < TIMEOUT) begin
         @(posedge i_clk);
         #2;
         t++;
      end
      if (producer_credits() == 0) begin
         errors++;
         $display("Timeout while the producer waited for an input credit");
      end else begin
         i_in_valid      = 1'b1;
         i_in_list_a     = a;
         i_in_list_b     = b;
         i_in_tag        = tag_t'(spent);
         exp_keys[spent] = exp;
         spent++;
         @(posedge i_clk);
         #2;
         i_in_valid = 1'b0;
      end
   endtask

   task automatic wait_idle(input string phase);
      int t = 0;
      while ((consumed != spent || producer_credits() != DEF_FIFO_DEPTH) && t < TIMEOUT) begin
         @(posedge i_clk);
         #2;
         t++;
      end
      if (consumed != spent || producer_credits() != DEF_FIFO_DEPTH) begin
         errors++;
         $display("Timeout while the %s phase waited for its blocks to drain", phase);
      end
      repeat (2) @(posedge i_clk);
      #2;
   endtask

   // Consumer and credit monitor, sampled away from the active edge.
   always @(negedge i_clk) begin
      if (i_arst_n) begin
         if (o_in_credit) begin
            returned++;
         end
         if (producer_credits() < 0 || producer_credits() > DEF_FIFO_DEPTH) begin
            errors++;
            $display("Producer credit count %0d is out of range", producer_credits());
         end
         if (o_out_valid) begin
            if (consumed >= spent) begin
               errors++;
               $display("An output block arrived with no block in flight");
            end else begin
               check_keys("o_out_keys", exp_keys[consumed], o_out_keys);
               check_tag("o_out_tag", tag_t'(consumed), o_out_tag);
            end
            consumed++;
         end
         give_ok = (policy == 0) || (policy == 2 && ($random(seed) % 2) != 0);
      end
   end

   always @(posedge i_clk) begin
      #2;
      i_out_credit = (consumed > given) && give_ok;
      if (i_out_credit) begin
         given++;
      end
   end

   initial begin
      list_t  a;
      list_t  b;
      block_t exp;
      int     base;
      i_clk       = 1'b0;
      i_arst_n    = 1'b0;
      i_in_valid  = 1'b0;
      i_in_list_a = '0;
      i_in_list_b = '0;
      i_in_tag    = '0;
      // Eight cycles in reset, then one more with reset released.
      for (int c = 0; c < 9; c++) begin
         @(posedge i_clk);
         #2;
         i_arst_n = (c >= 7);
         @(negedge i_clk);
         check_bit("o_out_valid", 1'b0, o_out_valid);
         check_bit("o_in_credit", 1'b0, o_in_credit);
      end
      @(posedge i_clk);
      #2;
      for (int v = 0; v < NUM_VEC; v++) begin
         for (int k = 0; k < DEF_BLK_N; k++) begin
            a[k] = VEC_A[v][k];
            b[k] = VEC_B[v][k];
         end
         for (int k = 0; k < NK; k++) begin
            exp[k] = VEC_EXP[v][k];
         end
         send_block(a, b, exp);
      end
      wait_idle("directed");
      policy = 1;
      base   = consumed;
      // The FIFO fills and the two blocks sent to the consumer free two more slots.
      repeat (DEF_FIFO_DEPTH + DEF_OUT_CREDITS) begin
         a = random_list();
         b = random_list();
         send_block(a, b, merge_expected(a, b));
      end
      repeat (20) @(posedge i_clk);
      #2;
      if (producer_credits() != 0 || consumed - base != DEF_OUT_CREDITS) begin
         errors++;
         $display("Back-pressure left %0d input credits and delivered %0d blocks",
                  producer_credits(), consumed - base);
      end
      policy = 0;
      wait_idle("back-pressure");
      policy = 2;
      repeat (N_RANDOM) begin
         a = random_list();
         b = random_list();
         send_block(a, b, merge_expected(a, b));
      end
      wait_idle("random");
      if (returned != consumed || consumed != spent) begin
         errors++;
         $display("Credit pulses %0d do not match blocks consumed %0d and sent %0d",
                  returned, consumed, spent);
      end
      $display("errors: %0d  blocks sent: %0d  blocks received: %0d", errors, spent, consumed);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/merge_unit_top.sv
// Top level of the streaming merge unit.
// Connects the merge network, the block FIFO and the output credit sender.

`timescale 1ns/1ps
`default_nettype none

module merge_unit_top
   import merge_pkg::*;
#(
   parameter int BLK_N       = DEF_BLK_N,
   parameter int FIFO_DEPTH  = DEF_FIFO_DEPTH,
   parameter int OUT_CREDITS = DEF_OUT_CREDITS
) (
   input  wire logic                 i_clk,
   input  wire logic                 i_arst_n,
   input  wire logic                 i_in_valid,
   input  wire key_t [BLK_N-1:0]     i_in_list_a,
   input  wire key_t [BLK_N-1:0]     i_in_list_b,
   input  wire tag_t                 i_in_tag,
   output logic                      o_in_credit,
   output logic                      o_out_valid,
   output key_t      [2*BLK_N-1:0]   o_out_keys,
   output tag_t                      o_out_tag,
   input  wire logic                 i_out_credit
);

   logic               net_valid;
   key_t [2*BLK_N-1:0] net_keys;
   tag_t               net_tag;
   logic               fifo_not_empty;
   key_t [2*BLK_N-1:0] fifo_keys;
   tag_t               fifo_tag;
   logic               fifo_pop;

   bitonic_merge_net #(
      .BLK_N (BLK_N)
   ) bitonic_merge_net_inst (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_valid  (i_in_valid),
      .i_keys   ({i_in_list_b, i_in_list_a}),  // List A fills the low half.
      .i_tag    (i_in_tag),
      .o_valid  (net_valid),
      .o_keys   (net_keys),
      .o_tag    (net_tag)
   );

   block_fifo #(
      .BLK_N      (BLK_N),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) block_fifo_inst (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_push       (net_valid),
      .i_keys       (net_keys),
      .i_tag        (net_tag),
      .i_pop        (fifo_pop),
      .o_not_empty  (fifo_not_empty),
      .o_keys       (fifo_keys),
      .o_tag        (fifo_tag),
      .o_pop_credit (o_in_credit)
   );

   credit_sender #(
      .BLK_N       (BLK_N),
      .OUT_CREDITS (OUT_CREDITS)
   ) credit_sender_inst (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_out_credit (i_out_credit),
      .i_not_empty  (fifo_not_empty),
      .i_keys       (fifo_keys),
      .i_tag        (fifo_tag),
      .o_pop        (fifo_pop),
      .o_out_valid  (o_out_valid),
      .o_out_keys   (o_out_keys),
      .o_out_tag    (o_out_tag)
   );

endmodule

`default_nettype wire

//--- hw/credit_sender.sv
// Output credit counter and output block register.
// Moves the FIFO head onto the output port while consumer credit remains.

`timescale 1ns/1ps
`default_nettype none

module credit_sender
   import merge_pkg::*;
#(
   parameter int BLK_N       = DEF_BLK_N,
   parameter int OUT_CREDITS = DEF_OUT_CREDITS
) (
   input  wire logic                 i_clk,
   input  wire logic                 i_arst_n,
   input  wire logic                 i_out_credit,
   input  wire logic                 i_not_empty,
   input  wire key_t [2*BLK_N-1:0]   i_keys,
   input  wire tag_t                 i_tag,
   output logic                      o_pop,
   output logic                      o_out_valid,
   output key_t      [2*BLK_N-1:0]   o_out_keys,
   output tag_t                      o_out_tag
);

   localparam int CNT_W = $clog2(OUT_CREDITS + 1);

   logic [CNT_W-1:0] credits;

   assign o_pop = i_not_empty && (credits != '0);

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         credits     <= CNT_W'(OUT_CREDITS);
         o_out_valid <= 1'b0;
      end else begin
         credits     <= credits + CNT_W'(i_out_credit) - CNT_W'(o_pop);  // Return and send may coincide.
         o_out_valid <= o_pop;
      end
   end

   always_ff @(posedge i_clk) begin
      if (o_pop) begin
         o_out_keys <= i_keys;
         o_out_tag  <= i_tag;
      end
   end

endmodule

`default_nettype wire

//--- hw/block_fifo.sv
// Circular buffer of merged blocks and their tags.
// Each pop returns one input credit on the following cycle.

`timescale 1ns/1ps
`default_nettype none

module block_fifo
   import merge_pkg::*;
#(
   parameter int BLK_N      = DEF_BLK_N,
   parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
   input  wire logic                 i_clk,
   input  wire logic                 i_arst_n,
   input  wire logic                 i_push,
   input  wire key_t [2*BLK_N-1:0]   i_keys,
   input  wire tag_t                 i_tag,
   input  wire logic                 i_pop,
   output logic                      o_not_empty,
   output key_t      [2*BLK_N-1:0]   o_keys,
   output tag_t                      o_tag,
   output logic                      o_pop_credit
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   key_t [2*BLK_N-1:0] mem_keys [FIFO_DEPTH];
   tag_t               mem_tag  [FIFO_DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [CNT_W-1:0]   count;

   always_ff @(posedge i_clk) begin
      if (i_push) begin
         mem_keys[wr_ptr] <= i_keys;
         mem_tag[wr_ptr]  <= i_tag;
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         count        <= '0;
         o_pop_credit <= 1'b0;
      end else begin
         if (i_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (i_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count        <= count + CNT_W'(i_push) - CNT_W'(i_pop);
         o_pop_credit <= i_pop;  // The freed slot goes back to the producer.
      end
   end

   assign o_not_empty = (count != '0);
   assign o_keys      = mem_keys[rd_ptr];
   assign o_tag       = mem_tag[rd_ptr];

endmodule

`default_nettype wire

//--- hw/bitonic_merge_net.sv
// Pipelined bitonic merge network.
// A mirrored column makes the two lists bitonic, then half-cleaner columns
// finish the merge. Valid bits and tags travel alongside the keys.

`timescale 1ns/1ps
`default_nettype none

module bitonic_merge_net
   import merge_pkg::*;
#(
   parameter int BLK_N = DEF_BLK_N
) (
   input  wire logic                 i_clk,
   input  wire logic                 i_arst_n,
   input  wire logic                 i_valid,
   input  wire key_t [2*BLK_N-1:0]   i_keys,
   input  wire tag_t                 i_tag,
   output logic                      o_valid,
   output key_t      [2*BLK_N-1:0]   o_keys,
   output tag_t                      o_tag
);

   localparam int NK     = 2 * BLK_N;
   localparam int STAGES = $clog2(NK);  // Mirror column plus log2(BLK_N) cleaners.

   wire key_t [NK-1:0] col_keys [STAGES];
   logic [STAGES-1:0]  stage_vld;
   tag_t               stage_tag [STAGES];

   for (genvar s = 0; s < STAGES; s++) begin : g_stage
      if (s == 0) begin : g_first
         cas_column #(
            .BLK_N  (BLK_N),
            .SPAN   (BLK_N),
            .MIRROR (1'b1)
         ) cas_column_inst (
            .i_clk    (i_clk),
            .i_arst_n (i_arst_n),
            .i_en     (i_valid),
            .i_keys   (i_keys),
            .o_keys   (col_keys[0])
         );
      end else begin : g_clean
         cas_column #(
            .BLK_N  (BLK_N),
            .SPAN   (BLK_N >> s),
            .MIRROR (1'b0)
         ) cas_column_inst (
            .i_clk    (i_clk),
            .i_arst_n (i_arst_n),
            .i_en     (stage_vld[s-1]),
            .i_keys   (col_keys[s-1]),
            .o_keys   (col_keys[s])
         );
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         stage_vld <= '0;
      end else begin
         stage_vld <= {stage_vld[STAGES-2:0], i_valid};
      end
   end

   // Tags follow the same enables as the key columns.
   always_ff @(posedge i_clk) begin
      if (i_valid) begin
         stage_tag[0] <= i_tag;
      end
      for (int s = 1; s < STAGES; s++) begin
         if (stage_vld[s-1]) begin
            stage_tag[s] <= stage_tag[s-1];
         end
      end
   end

   assign o_valid = stage_vld[STAGES-1];
   assign o_keys  = col_keys[STAGES-1];
   assign o_tag   = stage_tag[STAGES-1];

endmodule

`default_nettype wire

//--- hw/cas_column.sv
// One registered column of compare-and-swap cells.
// Pairs keys at a fixed span, or mirrored around the block center.

`timescale 1ns/1ps
`default_nettype none

module cas_column
   import merge_pkg::*;
#(
   parameter int BLK_N  = DEF_BLK_N,
   parameter int SPAN   = 1,
   parameter bit MIRROR = 1'b0
) (
   input  wire logic                 i_clk,
   input  wire logic                 i_arst_n,
   input  wire logic                 i_en,
   input  wire key_t [2*BLK_N-1:0]   i_keys,
   output key_t      [2*BLK_N-1:0]   o_keys
);

   localparam int NK = 2 * BLK_N;

   wire key_t [NK-1:0] cas_out;

   // Each cell owns one pair, so BLK_N cells cover every position once.
   for (genvar p = 0; p < BLK_N; p++) begin : g_cell
      localparam int LO = MIRROR ? p : (p / SPAN) * 2 * SPAN + (p % SPAN);
      localparam int HI = MIRROR ? (NK - 1 - p) : LO + SPAN;

      wire logic swap;

      assign swap        = i_keys[LO] > i_keys[HI];  // Smaller key goes low.
      assign cas_out[LO] = swap ? i_keys[HI] : i_keys[LO];
      assign cas_out[HI] = swap ? i_keys[LO] : i_keys[HI];
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_keys <= '0;
      end else if (i_en) begin
         o_keys <= cas_out;  // A bubble leaves the column unchanged.
      end
   end

endmodule

`default_nettype wire

//--- hw/merge_pkg.sv
// Shared types and default sizes for the streaming merge unit.
// Holds the key and tag types and the default block, FIFO and credit sizes.

`default_nettype none

package merge_pkg;

   // One unsigned sort key.
   typedef logic [31:0] key_t;

   // Block identifier carried next to the keys.
   typedef logic [7:0] tag_t;

   // Keys in each ascending input list, a power of two from 2 to 16.
   localparam int DEF_BLK_N = 8;

   // Block slots in the result FIFO, also the producer's initial credits.
   localparam int DEF_FIFO_DEPTH = 4;

   // Initial credits held toward the consumer.
   localparam int DEF_OUT_CREDITS = 2;

endpackage

`default_nettype wire
